// File: all.f
common/dmaPkg.sv
common/dmaControlIf.sv
common/ramPortIf.sv
logic/dualPortRam.sv
logic/ciRegisterFile.sv
dma/dmaEngine.sv
logic/ramDmaTop.sv
verification/busMemoryModel.sv
verification/ramDma_properties.sv
verification/ramDmaTb.sv

// File: Bender.yml
package:
  name: ram_dma

sources:
  - common/dmaPkg.sv
  - common/dmaControlIf.sv
  - common/ramPortIf.sv
  - logic/dualPortRam.sv
  - logic/ciRegisterFile.sv
  - dma/dmaEngine.sv
  - logic/ramDmaTop.sv
  - target: test
    files:
      - verification/busMemoryModel.sv
      - verification/ramDma_properties.sv
      - verification/ramDmaTb.sv

// File: verification/ramDmaTb.sv
`default_nettype none

module ramDmaTb;
  import dmaPkg::*;

  localparam logic [ciIdWidth-1:0] customId = 8'h2c;
  localparam int cycleLimit = 20000;

  logic                       clock = 1'b0;
  logic                       rstN;
  logic                       start;
  logic [ciIdWidth-1:0]       ciN;
  logic [dataWidth-1:0]       valueA;
  logic [dataWidth-1:0]       valueB;
  logic                       done;
  logic [dataWidth-1:0]       result;
  logic                       requestTransaction;
  logic                       beginTransaction;
  logic                       readNotWrite;
  logic                       endTransactionOut;
  logic                       dataValidOut;
  logic [byteEnableWidth-1:0] byteEnables;
  logic [burstWidth-1:0]      burstSize;
  logic [dataWidth-1:0]       addressDataOut;
  logic                       transactionGranted;
  logic                       endTransactionIn;
  logic                       dataValidIn;
  logic                       busError;
  logic                       busy;
  logic [dataWidth-1:0]       addressDataIn;
  logic                       armError;

  int                   errorCount = 0;
  int                   cycleCount = 0;
  int                   burstWords [$];
  logic [dataWidth-1:0] burstAddresses [$];

  ramDmaTop #(.customId(customId)) dut (.*);

  busMemoryModel slave (
    .clock(clock), .rstN(rstN), .requestTransaction(requestTransaction),
    .beginTransaction(beginTransaction), .readNotWrite(readNotWrite),
    .endTransactionOut(endTransactionOut), .dataValidOut(dataValidOut),
    .burstSize(burstSize), .addressDataOut(addressDataOut), .armError(armError),
    .transactionGranted(transactionGranted), .endTransactionIn(endTransactionIn),
    .dataValidIn(dataValidIn), .busError(busError), .busy(busy),
    .addressDataIn(addressDataIn)
  );

  always #2 clock = ~clock;

  // Burst log, read back after the DMA in test
  always @(negedge clock)
  begin
    if (rstN && beginTransaction)
    begin
      burstWords.push_back(int'(burstSize) + 1);
      burstAddresses.push_back(addressDataOut);
    end
  end

  always @(posedge clock)
  begin
    cycleCount++;
    if (cycleCount >= cycleLimit)
    begin
      $display("Run timed out after %0d cycles", cycleCount);
      $display("Check errors: %0d, property failures: %0d", errorCount,
               dut.protocolChecks.failureCount);
      $display("Done: errors found");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // Instruction helpers

  function automatic logic [dataWidth-1:0] ramOp(input logic write, input int address);
    return {21'b0, write, 10'(address)};
  endfunction

  function automatic logic [dataWidth-1:0] regWriteOp(input logic [3:0] code);
    return {18'b0, code, 10'b0};
  endfunction

  function automatic logic [dataWidth-1:0] regReadOp(input logic [2:0] select);
    return {18'b0, select, 11'b0};
  endfunction

  task automatic expectEqual(input logic [dataWidth-1:0] actual,
                             input logic [dataWidth-1:0] expected, input string what);
    assert (actual === expected)
    else
    begin
      errorCount++;
      $display("** Error at %0t: %s, got %h, expected %h", $time, what, actual, expected);
    end
  endtask

  // Writes finish in the request cycle, reads answer in the next one
  task automatic issue(input logic [dataWidth-1:0] a, input logic [dataWidth-1:0] b,
                       output logic [dataWidth-1:0] data);
    logic isRead;
    isRead = !a[10];
    @(posedge clock);
    #1;
    start  = 1'b1;
    ciN    = customId;
    valueA = a;
    valueB = b;
    @(negedge clock);
    expectEqual(done, !isRead, "done in the request cycle");
    if (isRead)
      expectEqual(result, '0, "result while done is low");
    @(posedge clock);
    #1;
    start  = 1'b0;
    valueA = '0;
    valueB = '0;
    @(negedge clock);
    expectEqual(done, isRead, "done in the cycle after the request");
    data = result;
    if (!isRead)
      expectEqual(result, '0, "result while done is low");
  endtask

  task automatic writeReg(input logic [3:0] code, input logic [dataWidth-1:0] value);
    logic [dataWidth-1:0] ignored;
    issue(regWriteOp(code), value, ignored);
  endtask

  task automatic readReg(input logic [2:0] select, output logic [dataWidth-1:0] value);
    issue(regReadOp(select), '0, value);
  endtask

  // Program, start and poll the status until busy falls
  task automatic runDma(input logic [dataWidth-1:0] busAddress, input int memAddress,
                        input int words, input int burstValue, input logic toRam,
                        output logic [dataWidth-1:0] status);
    writeReg(regBusAddr, busAddress);
    writeReg(regMemAddr, memAddress);
    writeReg(regBlockSize, words);
    writeReg(regBurstSize, burstValue);
    writeReg(regControl, toRam ? 32'd1 : 32'd2);
    do
    begin
      readReg(selStatus, status);
    end
    while (status[0]);
  endtask

  //////////////////////////////////////////////////
  // Tests

  initial
  begin
    logic [dataWidth-1:0] data;
    logic [dataWidth-1:0] first;
    logic [dataWidth-1:0] second;
    logic [dataWidth-1:0] expected [20];
    int                   i;

    void'($urandom(32'h06fe_4e44));
    rstN     = 1'b0;
    start    = 1'b0;
    ciN      = '0;
    valueA   = '0;
    valueB   = '0;
    armError = 1'b0;
    for (i = 0; i < 1024; i++)
      slave.memory[i] = $urandom;
    repeat (2) @(posedge clock);
    #1;
    rstN = 1'b1;

    // Direct RAM access
    first  = $urandom;
    second = $urandom;
    issue(ramOp(1'b1, 5), first, data);
    issue(ramOp(1'b1, 6), second, data);
    issue(ramOp(1'b0, 5), '0, data);
    expectEqual(data, first, "RAM word 5");
    issue(ramOp(1'b0, 6), '0, data);
    expectEqual(data, second, "RAM word 6");

    // Registers, truncated to their widths
    readReg(selStatus, data);
    expectEqual(data, '0, "status after reset");
    writeReg(regBusAddr, 32'ha5c3_9e17);
    readReg(selBusAddr, data);
    expectEqual(data, 32'ha5c3_9e17, "bus start address");
    writeReg(regMemAddr, '1);
    readReg(selMemAddr, data);
    expectEqual(data, 32'h1ff, "RAM start address");
    writeReg(regBlockSize, '1);
    readReg(selBlockSize, data);
    expectEqual(data, 32'h3ff, "block size");
    writeReg(regBurstSize, '1);
    readReg(selBurstSize, data);
    expectEqual(data, 32'hff, "burst size");

    // DMA in, 37 words in bursts of 8
    burstWords.delete();
    burstAddresses.delete();
    runDma(32'h200, 100, 37, 7, 1'b1, data);
    expectEqual(data, '0, "status after DMA in");
    expectEqual(burstWords.size(), 5, "number of bursts");
    for (i = 0; i < burstWords.size() && i < 5; i++)
    begin
      expectEqual(burstWords[i], (i < 4) ? 8 : 5, "burst length");
      expectEqual(burstAddresses[i], 32'h200 + 32 * i, "burst address");
    end
    for (i = 0; i < 37; i++)
    begin
      issue(ramOp(1'b0, 100 + i), '0, data);
      expectEqual(data, slave.memory[128 + i], "RAM word after DMA in");
    end

    // DMA out with busy stalls
    for (i = 0; i < 20; i++)
    begin
      expected[i] = $urandom;
      issue(ramOp(1'b1, 300 + i), expected[i], data);
    end
    runDma(32'h800, 300, 20, 3, 1'b0, data);
    expectEqual(data, '0, "status after DMA out");
    for (i = 0; i < 20; i++)
      expectEqual(slave.memory[512 + i], expected[i], "bus word after DMA out");

    // Bus error, then a clean transfer
    armError = 1'b1;
    runDma(32'h400, 400, 16, 7, 1'b1, data);
    expectEqual(data, 32'd2, "status after bus error");
    armError = 1'b0;
    runDma(32'h400, 400, 4, 3, 1'b1, data);
    expectEqual(data, '0, "status after clean transfer");

    $display("Check errors: %0d, property failures: %0d", errorCount,
             dut.protocolChecks.failureCount);
    if (errorCount == 0 && dut.protocolChecks.failureCount == 0)
      $display("Done: no errors");
    else
      $display("Done: errors found");
    $finish;
  end

endmodule

`default_nettype wire

// File: verification/ramDma_properties.sv
`default_nettype none

module ramDmaProperties (
  input logic                               clock,
  input logic                               rstN,
  input logic                               done,
  input logic [dmaPkg::dataWidth-1:0]       result,
  input logic                               requestTransaction,
  input logic                               transactionGranted,
  input logic                               beginTransaction,
  input logic [dmaPkg::byteEnableWidth-1:0] byteEnables,
  input logic                               dataValidOut,
  input logic                               busy,
  input logic                               busError,
  input logic [dmaPkg::dataWidth-1:0]       addressDataOut
);

  int failureCount = 0;

  resultIdleZero: assert property (@(posedge clock) disable iff (!rstN)
    !done |-> result == '0)
  else
  begin
    failureCount++;
    $error("result is not zero while done is low");
  end

  beginPulse: assert property (@(posedge clock) disable iff (!rstN)
    beginTransaction |-> (byteEnables == '1) ##1 !beginTransaction)
  else
  begin
    failureCount++;
    $error("beginTransaction is not a single cycle with all byte enables");
  end

  // Back-pressure holds the word, an error may drop it
  writeHold: assert property (@(posedge clock) disable iff (!rstN)
    dataValidOut && busy && !busError |=> dataValidOut && $stable(addressDataOut))
  else
  begin
    failureCount++;
    $error("write word changed while busy was high");
  end

  requestHold: assert property (@(posedge clock) disable iff (!rstN)
    requestTransaction && !transactionGranted |=> requestTransaction)
  else
  begin
    failureCount++;
    $error("requestTransaction dropped before the grant");
  end

endmodule

bind ramDmaTop ramDmaProperties protocolChecks (
  .clock              (clock),
  .rstN               (rstN),
  .done               (done),
  .result             (result),
  .requestTransaction (requestTransaction),
  .transactionGranted (transactionGranted),
  .beginTransaction   (beginTransaction),
  .byteEnables        (byteEnables),
  .dataValidOut       (dataValidOut),
  .busy               (busy),
  .busError           (busError),
  .addressDataOut     (addressDataOut)
);

`default_nettype wire

// File: verification/busMemoryModel.sv
`default_nettype none

module busMemoryModel (
  input  logic                          clock,
  input  logic                          rstN,
  input  logic                          requestTransaction,
  input  logic                          beginTransaction,
  input  logic                          readNotWrite,
  input  logic                          endTransactionOut,
  input  logic                          dataValidOut,
  input  logic [dmaPkg::burstWidth-1:0] burstSize,
  input  logic [dmaPkg::dataWidth-1:0]  addressDataOut,
  input  logic                          armError,      // Cut the next read burst short
  output logic                          transactionGranted,
  output logic                          endTransactionIn,
  output logic                          dataValidIn,
  output logic                          busError,
  output logic                          busy,
  output logic [dmaPkg::dataWidth-1:0]  addressDataIn
);
  import dmaPkg::*;

  typedef enum logic [1:0] {modelIdle, modelRead, modelReadEnd, modelWrite} phase_t;

  logic [dataWidth-1:0] memory [1024];  // Word memory, byte address bits 11:2
  phase_t               phase;
  logic [9:0]           wordAddress;
  int                   wordsLeft;
  int                   wordIndex;
  logic                 errorDone;

  logic                 grantNext;
  logic                 validNext;
  logic                 endNext;
  logic                 errorNext;
  logic                 busyNext;
  logic [dataWidth-1:0] dataNext;

  initial
  begin
    phase              = modelIdle;
    errorDone          = 1'b0;
    transactionGranted = 1'b0;
    endTransactionIn   = 1'b0;
    dataValidIn        = 1'b0;
    busError           = 1'b0;
    busy               = 1'b0;
    addressDataIn      = '0;
  end

  // Bus values are taken at the edge, answers go out one unit later
  always @(posedge clock)
  begin
    grantNext = 1'b0;
    validNext = 1'b0;
    endNext   = 1'b0;
    errorNext = 1'b0;
    busyNext  = 1'b0;
    dataNext  = '0;
    if (!armError)
      errorDone = 1'b0;
    if (!rstN)
      phase = modelIdle;
    else
    begin
      case (phase)
        modelIdle:
          if (beginTransaction)
          begin
            wordAddress = addressDataOut[11:2];
            wordsLeft   = int'(burstSize) + 1;
            wordIndex   = 0;
            phase       = readNotWrite ? modelRead : modelWrite;
          end
          else if (requestTransaction && !transactionGranted)
            grantNext = 1'($urandom_range(1));  // Grant after a random wait
        modelWrite:
          if (endTransactionOut)
            phase = modelIdle;
          else if (dataValidOut && !busy)
          begin
            memory[wordAddress] = addressDataOut;  // Word taken in this cycle
            wordAddress++;
          end
        modelReadEnd:
          phase = modelIdle;
        default: ;
      endcase

      if (phase == modelRead)
      begin
        if (wordsLeft == 0)
        begin
          endNext = 1'b1;
          phase   = modelReadEnd;
        end
        else if (armError && !errorDone && wordIndex == 3)
        begin
          errorNext = 1'b1;  // The end pulse follows in the next cycle
          errorDone = 1'b1;
          wordsLeft = 0;
        end
        else
        begin
          validNext = 1'b1;
          dataNext  = memory[wordAddress];
          wordAddress++;
          wordsLeft--;
          wordIndex++;
        end
      end
      else if (phase == modelWrite)
        busyNext = ($urandom_range(2) == 0);  // Stall about one cycle in three
    end
    #1;
    transactionGranted = grantNext;
    dataValidIn        = validNext;
    endTransactionIn   = endNext;
    busError           = errorNext;
    busy               = busyNext;
    addressDataIn      = dataNext;
  end

endmodule

`default_nettype wire

// File: logic/ramDmaTop.sv
`default_nettype none

module ramDmaTop #(
  parameter logic [dmaPkg::ciIdWidth-1:0] customId = '0
) (
  input  logic                               clock,
  input  logic                               rstN,
  // Instruction port
  input  logic                               start,
  input  logic [dmaPkg::ciIdWidth-1:0]       ciN,
  input  logic [dmaPkg::dataWidth-1:0]       valueA,
  input  logic [dmaPkg::dataWidth-1:0]       valueB,
  output logic                               done,
  output logic [dmaPkg::dataWidth-1:0]       result,
  // Burst bus
  output logic                               requestTransaction,
  output logic                               beginTransaction,
  output logic                               readNotWrite,
  output logic                               endTransactionOut,
  output logic                               dataValidOut,
  output logic [dmaPkg::byteEnableWidth-1:0] byteEnables,
  output logic [dmaPkg::burstWidth-1:0]      burstSize,
  output logic [dmaPkg::dataWidth-1:0]       addressDataOut,
  input  logic                               transactionGranted,
  input  logic                               endTransactionIn,
  input  logic                               dataValidIn,
  input  logic                               busError,
  input  logic                               busy,
  input  logic [dmaPkg::dataWidth-1:0]       addressDataIn
);
  import dmaPkg::*;

  // Processor side of the scratch RAM
  logic                    ramWriteEnable;
  logic [ramAddrWidth-1:0] ramAddress;
  logic [dataWidth-1:0]    ramWriteData;
  logic [dataWidth-1:0]    ramReadData;

  dmaControlIf controlBus ();
  ramPortIf    dmaRamPort ();

  ciRegisterFile #(
    .customId(customId)
  ) registerFile (
    .clock          (clock),
    .rstN           (rstN),
    .start          (start),
    .ciN            (ciN),
    .valueA         (valueA),
    .valueB         (valueB),
    .done           (done),
    .result         (result),
    .ramWriteEnable (ramWriteEnable),
    .ramAddress     (ramAddress),
    .ramWriteData   (ramWriteData),
    .ramReadData    (ramReadData),
    .control        (controlBus.regs)
  );

  dmaEngine engine (
    .clock              (clock),
    .rstN               (rstN),
    .control            (controlBus.engine),
    .ram                (dmaRamPort.engine),
    .requestTransaction (requestTransaction),
    .beginTransaction   (beginTransaction),
    .readNotWrite       (readNotWrite),
    .endTransactionOut  (endTransactionOut),
    .dataValidOut       (dataValidOut),
    .byteEnables        (byteEnables),
    .burstSize          (burstSize),
    .addressDataOut     (addressDataOut),
    .transactionGranted (transactionGranted),
    .endTransactionIn   (endTransactionIn),
    .dataValidIn        (dataValidIn),
    .busError           (busError),
    .busy               (busy),
    .addressDataIn      (addressDataIn)
  );

  dualPortRam scratchRam (
    .clock        (clock),
    .writeEnableA (ramWriteEnable),
    .addressA     (ramAddress),
    .dataInA      (ramWriteData),
    .dataOutA     (ramReadData),
    .portB        (dmaRamPort.ram)
  );

endmodule

`default_nettype wire

// File: dma/dmaEngine.sv
`default_nettype none

module dmaEngine (
  input  logic                               clock,
  input  logic                               rstN,
  dmaControlIf.engine                        control,
  ramPortIf.engine                           ram,
  output logic                               requestTransaction,
  output logic                               beginTransaction,
  output logic                               readNotWrite,
  output logic                               endTransactionOut,
  output logic                               dataValidOut,
  output logic [dmaPkg::byteEnableWidth-1:0] byteEnables,
  output logic [dmaPkg::burstWidth-1:0]      burstSize,
  output logic [dmaPkg::dataWidth-1:0]       addressDataOut,
  input  logic                               transactionGranted,
  input  logic                               endTransactionIn,
  input  logic                               dataValidIn,
  input  logic                               busError,
  input  logic                               busy,
  input  logic [dmaPkg::dataWidth-1:0]       addressDataIn
);
  import dmaPkg::*;

  logic [stateWidth-1:0] stateReg;
  logic [stateWidth-1:0] nextState;
  logic                  isReadReg;
  logic                  busErrorReg;

  logic                 endTransactionInReg;
  logic                 dataValidInReg;
  logic [dataWidth-1:0] addressDataInReg;

  // Shadow counters, the register file values stay untouched
  logic [dataWidth-1:0]      busAddressReg;
  logic [blockSizeWidth-1:0] remainingReg;
  logic [ramAddrWidth-1:0]   ramAddressReg;

  logic [burstWidth:0]  wordsLeftReg;  // MSB set once the last word is loaded
  logic [dataWidth-1:0] dataOutReg;
  logic                 dataValidOutReg;
  logic                 outputFree;
  logic                 loadWord;
  logic                 storeWord;
  logic                 advance;
  logic                 transferDone;

  logic [blockSizeWidth-1:0] maxBurst;
  logic [blockSizeWidth-1:0] remainingMinusOne;
  logic [burstWidth-1:0]     thisBurst;

  //////////////////////////////////////////////////
  // Bus inputs and burst sizing

  always_ff @(posedge clock)
  begin
    if (!rstN)
    begin
      endTransactionInReg <= 1'b0;
      dataValidInReg      <= 1'b0;
    end
    else
    begin
      endTransactionInReg <= endTransactionIn;
      dataValidInReg      <= dataValidIn;
    end
  end

  always_ff @(posedge clock)
  begin
    addressDataInReg <= addressDataIn;
  end

  assign maxBurst          = blockSizeWidth'(control.burstSize) + 1'b1;
  assign remainingMinusOne = remainingReg - 1'b1;
  assign thisBurst = (remainingReg > maxBurst) ? control.burstSize
                                               : remainingMinusOne[burstWidth-1:0];

  // Word strobes
  assign storeWord  = (stateReg == stDoRead) && dataValidInReg;
  assign outputFree = !dataValidOutReg || !busy;   // Current word gone this cycle
  assign loadWord   = (stateReg == stDoWrite) && outputFree && !wordsLeftReg[burstWidth]
                      && !busError;
  assign advance    = storeWord || loadWord;

  // Last word and end of transaction may arrive together
  assign transferDone = (remainingReg == '0)
                        || ((remainingReg == blockSizeWidth'(1)) && storeWord);

  //////////////////////////////////////////////////
  // FSM

  always_comb
  begin
    nextState = stateReg;
    case (stateReg)
      stIdle:
        if (control.startIn || control.startOut)
          nextState = stInit;
      stInit:
        nextState = (control.blockSize == '0) ? stIdle : stRequestBus;
      stRequestBus:
        if (transactionGranted)
          nextState = stSetUp;
      stSetUp:
        nextState = isReadReg ? stDoRead : stDoWrite;
      stDoRead:
        if (endTransactionInReg)
          nextState = (transferDone || busError) ? stIdle : stRequestBus;
        else if (busError)
          nextState = stWaitEnd;                  // Slave still closes the burst
      stWaitEnd:
        if (endTransactionInReg)
          nextState = stIdle;
      stDoWrite:
        if (busError)
          nextState = stEndError;
        else if (wordsLeftReg[burstWidth] && outputFree)
          nextState = stEndWrite;
      stEndWrite:
        nextState = (remainingReg == '0) ? stIdle : stRequestBus;
      stEndError:
        nextState = stIdle;
      default:
        nextState = stIdle;
    endcase
  end

  always_ff @(posedge clock)
  begin
    if (!rstN)
    begin
      stateReg    <= stIdle;
      isReadReg   <= 1'b0;
      busErrorReg <= 1'b0;
    end
    else
    begin
      stateReg <= nextState;
      if (stateReg == stIdle)
        isReadReg <= control.startIn;
      if (stateReg == stInit)
        busErrorReg <= 1'b0;
      else if (busError && (stateReg == stDoRead || stateReg == stDoWrite))
        busErrorReg <= 1'b1;
    end
  end

  always_ff @(posedge clock)
  begin
    if (stateReg == stInit)
    begin
      busAddressReg <= control.busStartAddress;
      remainingReg  <= control.blockSize;
      ramAddressReg <= ramAddrWidth'(control.memStartAddress);
    end
    else if (advance)
    begin
      busAddressReg <= busAddressReg + dataWidth'(4);
      remainingReg  <= remainingMinusOne;
      ramAddressReg <= ramAddressReg + 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // Write datapath: RAM read, output register, bus

  always_ff @(posedge clock)
  begin
    if (!rstN)
      wordsLeftReg <= '0;
    else if (stateReg == stSetUp)
      wordsLeftReg <= {1'b0, thisBurst};
    else if (loadWord)
      wordsLeftReg <= wordsLeftReg - 1'b1;
  end

  always_ff @(posedge clock)
  begin
    if (!rstN)
      dataValidOutReg <= 1'b0;
    else if (stateReg != stDoWrite || busError)
      dataValidOutReg <= 1'b0;
    else if (outputFree)
      dataValidOutReg <= loadWord;  // Held while busy
  end

  always_ff @(posedge clock)
  begin
    if (loadWord)
      dataOutReg <= ram.readData;
  end

  // Look one word ahead on a load so readData always shows mem[ramAddressReg]
  assign ram.address     = ramAddressReg + ramAddrWidth'(loadWord);
  assign ram.writeEnable = storeWord;
  assign ram.writeData   = addressDataInReg;

  // Bus outputs
  assign requestTransaction = (stateReg == stRequestBus);
  assign beginTransaction   = (stateReg == stSetUp);
  assign readNotWrite       = beginTransaction && isReadReg;
  assign byteEnables        = beginTransaction ? '1 : '0;
  assign burstSize          = beginTransaction ? thisBurst : '0;
  assign endTransactionOut  = (stateReg == stEndWrite) || (stateReg == stEndError);
  assign dataValidOut       = dataValidOutReg;
  assign addressDataOut     = beginTransaction ? {busAddressReg[dataWidth-1:2], 2'b00}
                            : dataValidOutReg  ? dataOutReg
                            : '0;

  assign control.busy     = (stateReg != stIdle);
  assign control.busError = busErrorReg;

endmodule

`default_nettype wire

// File: logic/ciRegisterFile.sv
`default_nettype none

module ciRegisterFile #(
  parameter logic [dmaPkg::ciIdWidth-1:0] customId = '0
) (
  input  logic                            clock,
  input  logic                            rstN,
  input  logic                            start,
  input  logic [dmaPkg::ciIdWidth-1:0]    ciN,
  input  logic [dmaPkg::dataWidth-1:0]    valueA,
  input  logic [dmaPkg::dataWidth-1:0]    valueB,
  output logic                            done,
  output logic [dmaPkg::dataWidth-1:0]    result,
  output logic                            ramWriteEnable,
  output logic [dmaPkg::ramAddrWidth-1:0] ramAddress,
  output logic [dmaPkg::dataWidth-1:0]    ramWriteData,
  input  logic [dmaPkg::dataWidth-1:0]    ramReadData,
  dmaControlIf.regs                       control
);
  import dmaPkg::*;

  ciOperand_t operand;
  logic       accepted;
  logic       isWrite;
  logic       regHit;
  logic       readPendingReg;
  logic [2:0] readSelectReg;

  logic [dataWidth-1:0]      busStartAddressReg;
  logic [memAddrWidth-1:0]   memStartAddressReg;
  logic [blockSizeWidth-1:0] blockSizeReg;
  logic [burstWidth-1:0]     burstSizeReg;
  logic [dataWidth-1:0]      readValue;

  //////////////////////////////////////////////////
  // Instruction decode

  assign operand  = valueA;
  assign accepted = start && (ciN == customId);
  assign isWrite  = operand.ramView.writeFlag;
  assign regHit   = accepted && isWrite;

  // Register codes put nonzero bits in the RAM view's upper field, so no overlap
  assign ramWriteEnable = regHit && (operand.ramView.upper == '0);
  assign ramAddress     = operand.ramView.address;
  assign ramWriteData   = valueB;

  assign control.startIn  = regHit && (operand.regView.regCode == regControl)
                            && (valueB[1:0] == 2'b01);
  assign control.startOut = regHit && (operand.regView.regCode == regControl)
                            && (valueB[1:0] == 2'b10);

  //////////////////////////////////////////////////
  // Control registers

  always_ff @(posedge clock)
  begin
    if (!rstN)
    begin
      busStartAddressReg <= '0;
      memStartAddressReg <= '0;
      blockSizeReg       <= '0;
      burstSizeReg       <= '0;
    end
    else if (regHit)
    begin
      case (operand.regView.regCode)
        regBusAddr:   busStartAddressReg <= valueB;
        regMemAddr:   memStartAddressReg <= valueB[memAddrWidth-1:0];
        regBlockSize: blockSizeReg       <= valueB[blockSizeWidth-1:0];
        regBurstSize: burstSizeReg       <= valueB[burstWidth-1:0];
        default: ;
      endcase
    end
  end

  assign control.busStartAddress = busStartAddressReg;
  assign control.memStartAddress = memStartAddressReg;
  assign control.blockSize       = blockSizeReg;
  assign control.burstSize       = burstSizeReg;

  //////////////////////////////////////////////////
  // Read path, answer one cycle later

  always_ff @(posedge clock)
  begin
    if (!rstN)
      readPendingReg <= 1'b0;
    else
      readPendingReg <= accepted && !isWrite;
  end

  always_ff @(posedge clock)
  begin
    if (accepted && !isWrite)
      readSelectReg <= operand.regView.regCode[3:1];
  end

  always_comb
  begin
    case (readSelectReg)
      selRam:       readValue = ramReadData;  // Address was given with the request
      selBusAddr:   readValue = busStartAddressReg;
      selMemAddr:   readValue = dataWidth'(memStartAddressReg);
      selBlockSize: readValue = dataWidth'(blockSizeReg);
      selBurstSize: readValue = dataWidth'(burstSizeReg);
      selStatus:    readValue = dataWidth'({control.busError, control.busy});
      default:      readValue = '0;
    endcase
  end

  assign done   = regHit || readPendingReg;  // Writes finish in the same cycle
  assign result = readPendingReg ? readValue : '0;

endmodule

`default_nettype wire

// File: logic/dualPortRam.sv
`default_nettype none

module dualPortRam (
  input  logic                            clock,
  input  logic                            writeEnableA,
  input  logic [dmaPkg::ramAddrWidth-1:0] addressA,
  input  logic [dmaPkg::dataWidth-1:0]    dataInA,
  output logic [dmaPkg::dataWidth-1:0]    dataOutA,
  ramPortIf.ram                           portB
);
  import dmaPkg::*;

  logic [dataWidth-1:0] memory [ramDepth];

  // Both sides on the same clock, registered reads (old data on a same-cycle write)
  always_ff @(posedge clock)
  begin
    if (writeEnableA)
      memory[addressA] <= dataInA;               // Processor side
    if (portB.writeEnable)
      memory[portB.address] <= portB.writeData;  // DMA side
    dataOutA       <= memory[addressA];
    portB.readData <= memory[portB.address];
  end

endmodule

`default_nettype wire

// File: common/ramPortIf.sv
`default_nettype none

interface ramPortIf;
  import dmaPkg::*;

  logic [ramAddrWidth-1:0] address;
  logic                    writeEnable;
  logic [dataWidth-1:0]    writeData;
  logic [dataWidth-1:0]    readData;   // One cycle after address

  modport engine (output address, writeEnable, writeData, input readData);
  modport ram (input address, writeEnable, writeData, output readData);

endinterface

`default_nettype wire

// File: common/dmaControlIf.sv
`default_nettype none

interface dmaControlIf;
  import dmaPkg::*;

  // Configuration from the register file
  logic [dataWidth-1:0]      busStartAddress;
  logic [memAddrWidth-1:0]   memStartAddress;
  logic [blockSizeWidth-1:0] blockSize;
  logic [burstWidth-1:0]     burstSize;
  logic                      startIn;   // Bus to RAM
  logic                      startOut;  // RAM to bus

  // Status from the engine
  logic busy;
  logic busError;

  modport regs (
    output busStartAddress, memStartAddress, blockSize, burstSize, startIn, startOut,
    input  busy, busError
  );

  modport engine (
    input  busStartAddress, memStartAddress, blockSize, burstSize, startIn, startOut,
    output busy, busError
  );

endinterface

`default_nettype wire

// File: common/dmaPkg.sv
`default_nettype none

package dmaPkg;

  localparam int dataWidth       = 32;
  localparam int ramAddrWidth    = 10;
  localparam int ramDepth        = 1024;
  localparam int memAddrWidth    = 9;   // RAM start register is one bit short of the RAM
  localparam int blockSizeWidth  = 10;
  localparam int burstWidth      = 8;   // Burst value is words minus one
  localparam int ciIdWidth       = 8;
  localparam int byteEnableWidth = dataWidth / 8;
  localparam int stateWidth      = 4;

  // Register codes, valueA[13:10]
  localparam logic [3:0] regBusAddr   = 4'd3;
  localparam logic [3:0] regMemAddr   = 4'd5;
  localparam logic [3:0] regBlockSize = 4'd7;
  localparam logic [3:0] regBurstSize = 4'd9;
  localparam logic [3:0] regControl   = 4'd11;

  // Read selectors, valueA[13:11]
  localparam logic [2:0] selRam       = 3'd0;
  localparam logic [2:0] selBusAddr   = 3'd1;
  localparam logic [2:0] selMemAddr   = 3'd2;
  localparam logic [2:0] selBlockSize = 3'd3;
  localparam logic [2:0] selBurstSize = 3'd4;
  localparam logic [2:0] selStatus    = 3'd5;

  // DMA FSM
  localparam logic [stateWidth-1:0] stIdle       = 4'd0;
  localparam logic [stateWidth-1:0] stInit       = 4'd1;
  localparam logic [stateWidth-1:0] stRequestBus = 4'd2;
  localparam logic [stateWidth-1:0] stSetUp      = 4'd3;
  localparam logic [stateWidth-1:0] stDoRead     = 4'd4;
  localparam logic [stateWidth-1:0] stWaitEnd    = 4'd5;
  localparam logic [stateWidth-1:0] stDoWrite    = 4'd6;
  localparam logic [stateWidth-1:0] stEndError   = 4'd7;
  localparam logic [stateWidth-1:0] stEndWrite   = 4'd8;

  // Same valueA word, seen as a RAM access or as a register access
  typedef union packed {
    struct packed {
      logic [20:0]             upper;     // Must be zero for a RAM write
      logic                    writeFlag;
      logic [ramAddrWidth-1:0] address;
    } ramView;
    struct packed {
      logic [17:0] upper;
      logic [3:0]  regCode;
      logic [9:0]  lowBits;
    } regView;
  } ciOperand_t;

endpackage

`default_nettype wire
